// ==== src/cop_pkg.sv ====
// ========================================
// Coprocessor shared types and encodings
// ========================================
package cop_pkg;

    typedef logic [31:0] word_t;        // Register and operand data
    typedef logic [3:0]  cpr_addr_t;    // Coprocessor register index
    typedef logic [4:0]  gpr_addr_t;    // CPU register index
    typedef logic [1:0]  pack_width_t;  // 0=32b 1=16b 2=8b 3=4b lanes
    typedef logic [4:0]  shamt_t;       // Rotate amount or permute mask
    typedef logic [3:0]  opcode_t;      // Operation code
    typedef logic [2:0]  result_t;      // Execution result to CPU

    localparam opcode_t OP_PADD   = 4'd0;   // Packed add
    localparam opcode_t OP_PSUB   = 4'd1;   // Packed subtract
    localparam opcode_t OP_PXOR   = 4'd2;   // Bitwise xor
    localparam opcode_t OP_PROR   = 4'd3;   // Packed rotate right
    localparam opcode_t OP_MV_G2X = 4'd4;   // GPR to CPR move
    localparam opcode_t OP_MV_X2G = 4'd5;   // CPR to GPR move
    localparam opcode_t OP_GREV   = 4'd6;   // Generalized reverse
    localparam opcode_t OP_PBREV  = 4'd7;   // Per-lane bit reverse

    // Low bit of each instruction field, widths follow the types
    localparam int OP_LSB   = 28;
    localparam int CRD_LSB  = 24;
    localparam int CRS1_LSB = 20;
    localparam int CRS2_LSB = 16;
    localparam int PW_LSB   = 14;
    localparam int IMM_LSB  = 8;
    localparam int RD_LSB   = 0;

    localparam result_t RESULT_SUCCESS = 3'd0;  // Normal completion
    localparam result_t RESULT_BAD_INS = 3'd1;  // Illegal opcode

    typedef enum logic [1:0] {
        ST_WAIT,    // Ready for a request
        ST_ISSUE,   // Dispatch to a unit
        ST_EXEC,    // Unit working
        ST_DONE     // Response held for CPU
    } issue_state_t;

endpackage

// ==== src/cop_ifs.sv ====
// ========================================
// Unit dispatch bus and destination bus
// ========================================
`timescale 1ns/1ps

interface cop_unit_if;

    logic                  start;   // One-cycle dispatch strobe
    cop_pkg::opcode_t      op;
    cop_pkg::pack_width_t  pw;
    cop_pkg::shamt_t       imm;
    cop_pkg::word_t        opnd_a;  // CPR crs1 value
    cop_pkg::word_t        opnd_b;  // CPR crs2 or GPR rs1
    logic                  done;    // One cycle after start
    cop_pkg::word_t        wdata;   // Valid with done

    modport issuer (output start, op, pw, imm, opnd_a, opnd_b);
    modport unit   (input start, op, pw, imm, opnd_a, opnd_b, output done, wdata);
    modport sink   (input done, wdata);

endinterface

interface cop_dest_if;

    cop_pkg::cpr_addr_t  crd;     // CPR destination
    cop_pkg::gpr_addr_t  rd;      // GPR destination
    logic                wr_cpr;  // Result goes to CPR
    logic                wr_gpr;  // Result goes back to CPU

    modport source (output crd, rd, wr_cpr, wr_gpr);
    modport sink   (input crd, rd, wr_cpr, wr_gpr);

endinterface

// ==== src/cop_decoder.sv ====
// ========================================
// Instruction latch and field decode
// ========================================
`timescale 1ns/1ps

module cop_decoder (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  i_accept,     // Request taken this edge
    input  cop_pkg::word_t        i_insn_enc,
    input  cop_pkg::word_t        i_gpr_rs1,
    output cop_pkg::opcode_t      o_op,
    output cop_pkg::pack_width_t  o_pw,
    output cop_pkg::shamt_t       o_imm,
    output cop_pkg::cpr_addr_t    o_crs1,
    output cop_pkg::cpr_addr_t    o_crs2,
    output cop_pkg::word_t        o_gpr_rs1,
    output logic                  o_illegal,
    cop_dest_if.source            dest
);

    cop_pkg::word_t r_enc;  // Held until next accept
    cop_pkg::word_t r_rs1;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            r_enc <= '0;                // Decodes as a harmless PADD
        end else if (i_accept) begin
            r_enc <= i_insn_enc;
            r_rs1 <= i_gpr_rs1;
        end
    end

    assign o_op      = r_enc[cop_pkg::OP_LSB   +: $bits(cop_pkg::opcode_t)];
    assign o_pw      = r_enc[cop_pkg::PW_LSB   +: $bits(cop_pkg::pack_width_t)];
    assign o_imm     = r_enc[cop_pkg::IMM_LSB  +: $bits(cop_pkg::shamt_t)];
    assign o_crs1    = r_enc[cop_pkg::CRS1_LSB +: $bits(cop_pkg::cpr_addr_t)];
    assign o_crs2    = r_enc[cop_pkg::CRS2_LSB +: $bits(cop_pkg::cpr_addr_t)];
    assign o_gpr_rs1 = r_rs1;

    assign o_illegal = (o_op > cop_pkg::OP_PBREV);  // Codes 8..15 undefined

    assign dest.crd    = r_enc[cop_pkg::CRD_LSB +: $bits(cop_pkg::cpr_addr_t)];
    assign dest.rd     = r_enc[cop_pkg::RD_LSB  +: $bits(cop_pkg::gpr_addr_t)];
    assign dest.wr_gpr = !o_illegal && (o_op == cop_pkg::OP_MV_X2G);  // Only move-out
    assign dest.wr_cpr = !o_illegal && (o_op != cop_pkg::OP_MV_X2G);

endmodule

// ==== src/cop_regfile.sv ====
// ========================================
// 16 x 32-bit coprocessor register file
// ========================================
`timescale 1ns/1ps

module cop_regfile (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  cop_pkg::cpr_addr_t  i_raddr_a,
    output cop_pkg::word_t      o_rdata_a,
    input  cop_pkg::cpr_addr_t  i_raddr_b,
    output cop_pkg::word_t      o_rdata_b,
    input  logic                i_wen,
    input  cop_pkg::cpr_addr_t  i_waddr,
    input  cop_pkg::word_t      i_wdata
);

    cop_pkg::word_t regs [16];  // CPR storage

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            regs <= '{default: '0};     // All CPRs read zero after reset
        end else if (i_wen) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata_a = regs[i_raddr_a];  // Combinational reads
    assign o_rdata_b = regs[i_raddr_b];

    // Writeback must come out of reset with its write strobe cleared
    a_no_wr_in_reset: assert property (@(posedge g_clk) !g_resetn |=> !i_wen)
        else $error("CPR write requested straight after reset");

endmodule

// ==== src/cop_issue.sv ====
// ========================================
// CPU handshake FSM and unit dispatch
// ========================================
`timescale 1ns/1ps

module cop_issue (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  i_cpu_insn_req,
    output logic                  o_cop_insn_ack,
    output logic                  o_cop_insn_rsp,
    input  logic                  i_cpu_insn_ack,
    output logic                  o_accept,
    input  cop_pkg::opcode_t      i_op,
    input  cop_pkg::pack_width_t  i_pw,
    input  cop_pkg::shamt_t       i_imm,
    input  logic                  i_illegal,
    input  cop_pkg::word_t        i_gpr_rs1,
    input  cop_pkg::word_t        i_rdata_a,
    input  cop_pkg::word_t        i_rdata_b,
    output logic                  o_reject,
    input  logic                  i_finish,
    cop_unit_if.issuer            palu,
    cop_unit_if.issuer            perm
);

    cop_pkg::issue_state_t state, n_state;
    logic n_ack, n_rsp;
    logic retire;   // CPU took the response
    logic to_perm;  // Permute unit handles this op
    logic dispatch;

    assign o_accept = i_cpu_insn_req && o_cop_insn_ack;
    assign retire   = o_cop_insn_rsp && i_cpu_insn_ack;

    always_comb begin
        n_state = state;
        case (state)
            cop_pkg::ST_WAIT:  if (o_accept) n_state = cop_pkg::ST_ISSUE;
            cop_pkg::ST_ISSUE: n_state = i_finish ? cop_pkg::ST_DONE : cop_pkg::ST_EXEC;
            cop_pkg::ST_EXEC:  if (i_finish) n_state = cop_pkg::ST_DONE;
            cop_pkg::ST_DONE:  if (retire) n_state = cop_pkg::ST_WAIT;
            default:           n_state = cop_pkg::ST_WAIT;
        endcase
    end

    // Ack stays high while idle, response holds until the CPU takes it
    assign n_ack = ((state == cop_pkg::ST_WAIT) && !o_accept) ||
                   ((state == cop_pkg::ST_DONE) && retire);
    assign n_rsp = (state == cop_pkg::ST_DONE) && !retire;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state          <= cop_pkg::ST_WAIT;
            o_cop_insn_ack <= 1'b0;
            o_cop_insn_rsp <= 1'b0;
        end else begin
            state          <= n_state;
            o_cop_insn_ack <= n_ack;
            o_cop_insn_rsp <= n_rsp;
        end
    end

    assign to_perm  = (i_op == cop_pkg::OP_GREV) || (i_op == cop_pkg::OP_PBREV);
    assign dispatch = (state == cop_pkg::ST_ISSUE);
    assign o_reject = dispatch && i_illegal;   // No unit for codes 8..15

    assign palu.start  = dispatch && !i_illegal && !to_perm;
    assign palu.op     = i_op;
    assign palu.pw     = i_pw;
    assign palu.imm    = i_imm;
    assign palu.opnd_a = i_rdata_a;
    assign palu.opnd_b = (i_op == cop_pkg::OP_MV_G2X) ? i_gpr_rs1 : i_rdata_b;

    assign perm.start  = dispatch && !i_illegal && to_perm;
    assign perm.op     = i_op;
    assign perm.pw     = i_pw;
    assign perm.imm    = i_imm;
    assign perm.opnd_a = i_rdata_a;
    assign perm.opnd_b = i_rdata_b;

    a_ack_rsp_excl: assert property (@(posedge g_clk) o_cop_insn_ack |-> !o_cop_insn_rsp)
        else $error("Acknowledge and response high together");

endmodule

// ==== src/cop_packed_alu.sv ====
// ========================================
// Packed add, subtract, rotate, xor, move
// ========================================
`timescale 1ns/1ps

module cop_packed_alu (
    input  logic   g_clk,
    input  logic   g_resetn,
    cop_unit_if.unit bus
);

    logic            is_sub;
    logic            carry;     // Ripples nibble to nibble
    logic [2:0]      nib_mask;  // Nibbles per lane minus one
    cop_pkg::shamt_t lane_mask; // Bits per lane minus one
    cop_pkg::shamt_t rot_src;
    cop_pkg::word_t  b_add;
    cop_pkg::word_t  sum_res;
    cop_pkg::word_t  rot_res;
    cop_pkg::word_t  result;

    assign is_sub    = (bus.op == cop_pkg::OP_PSUB);
    assign b_add     = is_sub ? ~bus.opnd_b : bus.opnd_b;  // a + ~b + 1
    assign nib_mask  = 3'h7 >> bus.pw;
    assign lane_mask = 5'h1f >> bus.pw;

    // 4-bit slices so every lane width shares one chain
    always_comb begin
        carry = is_sub;
        for (int k = 0; k < 8; k++) begin
            if ((3'(k) & nib_mask) == 3'd0) begin
                carry = is_sub;    // Cut at lane boundary
            end
            {carry, sum_res[4*k +: 4]} = bus.opnd_a[4*k +: 4] + b_add[4*k +: 4] + carry;
        end
    end

    // Bit i takes bit i+imm of its own lane, wrapping inside the lane
    always_comb begin
        rot_src = '0;
        for (int i = 0; i < 32; i++) begin
            rot_src    = (5'(i) & ~lane_mask) | ((5'(i) + bus.imm) & lane_mask);
            rot_res[i] = bus.opnd_a[rot_src];
        end
    end

    always_comb begin
        case (bus.op)
            cop_pkg::OP_PADD,
            cop_pkg::OP_PSUB:   result = sum_res;
            cop_pkg::OP_PXOR:   result = bus.opnd_a ^ bus.opnd_b;
            cop_pkg::OP_PROR:   result = rot_res;
            cop_pkg::OP_MV_G2X: result = bus.opnd_b;   // GPR value in
            default:            result = bus.opnd_a;   // MV_X2G passes crs1
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            bus.done <= 1'b0;
        end else begin
            bus.done <= bus.start;
        end
    end

    always_ff @(posedge g_clk) begin
        if (bus.start) begin
            bus.wdata <= result;
        end
    end

    // Issue sends single strobes and the result is back next cycle
    a_done_after_start: assert property (@(posedge g_clk) disable iff (!g_resetn)
        bus.start |=> bus.done && !bus.start)
        else $error("Packed ALU done or start out of step");

endmodule

// ==== src/cop_permute_unit.sv ====
// ========================================
// Generalized and per-lane bit reversal
// ========================================
`timescale 1ns/1ps

module cop_permute_unit (
    input  logic   g_clk,
    input  logic   g_resetn,
    cop_unit_if.unit bus
);

    cop_pkg::shamt_t mask;    // Swap stages to apply
    cop_pkg::word_t  result;

    // Swap blocks of 1, 2, 4, 8, 16 bits per mask bit, lowest first
    function automatic cop_pkg::word_t grev(input cop_pkg::word_t x, input cop_pkg::shamt_t k);
        cop_pkg::word_t r;
        r = x;
        if (k[0]) r = ((r & 32'h5555_5555) << 1)  | ((r >> 1)  & 32'h5555_5555);
        if (k[1]) r = ((r & 32'h3333_3333) << 2)  | ((r >> 2)  & 32'h3333_3333);
        if (k[2]) r = ((r & 32'h0f0f_0f0f) << 4)  | ((r >> 4)  & 32'h0f0f_0f0f);
        if (k[3]) r = ((r & 32'h00ff_00ff) << 8)  | ((r >> 8)  & 32'h00ff_00ff);
        if (k[4]) r = ((r & 32'h0000_ffff) << 16) | ((r >> 16) & 32'h0000_ffff);
        return r;
    endfunction

    // Reversal inside a lane is a grev over all of its index bits
    assign mask   = (bus.op == cop_pkg::OP_PBREV) ? (5'h1f >> bus.pw) : bus.imm;
    assign result = grev(bus.opnd_a, mask);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            bus.done <= 1'b0;
        end else begin
            bus.done <= bus.start;   // Fixed one-cycle latency
        end
    end

    always_ff @(posedge g_clk) begin
        if (bus.start) begin
            bus.wdata <= result;
        end
    end

endmodule

// ==== src/cop_writeback.sv ====
// ========================================
// Result merge into CPR or GPR response
// ========================================
`timescale 1ns/1ps

module cop_writeback (
    input  logic                g_clk,
    input  logic                g_resetn,
    cop_unit_if.sink            palu,
    cop_unit_if.sink            perm,
    cop_dest_if.sink            dest,
    input  logic                i_reject,     // Illegal, no unit ran
    output logic                o_finish,
    output logic                o_cpr_wen,
    output cop_pkg::cpr_addr_t  o_cpr_waddr,
    output cop_pkg::word_t      o_cpr_wdata,
    output logic                o_cop_wen,
    output cop_pkg::gpr_addr_t  o_cop_waddr,
    output cop_pkg::word_t      o_cop_wdata,
    output cop_pkg::result_t    o_cop_result
);

    logic           p_valid;  // Result staged last cycle
    logic           p_cpr;    // Staged CPR write
    logic           p_gpr;
    logic           p_bad;
    cop_pkg::word_t p_data;

    assign o_finish = palu.done || perm.done || i_reject;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            p_valid <= 1'b0;
            p_cpr   <= 1'b0;
        end else begin
            p_valid <= o_finish;
            p_cpr   <= o_finish && !i_reject && dest.wr_cpr;
        end
    end

    always_ff @(posedge g_clk) begin
        if (o_finish) begin
            p_gpr  <= !i_reject && dest.wr_gpr;
            p_bad  <= i_reject;
            p_data <= palu.done ? palu.wdata : perm.wdata;   // Only one is done
        end
    end

    // Decoder holds crd until the next accept, well after this write
    assign o_cpr_wen   = p_cpr;
    assign o_cpr_waddr = dest.crd;
    assign o_cpr_wdata = p_data;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_cop_wen    <= 1'b0;
            o_cop_result <= cop_pkg::RESULT_SUCCESS;
        end else if (p_valid) begin
            o_cop_wen    <= p_gpr;
            o_cop_result <= p_bad ? cop_pkg::RESULT_BAD_INS : cop_pkg::RESULT_SUCCESS;
        end
    end

    always_ff @(posedge g_clk) begin
        if (p_valid) begin
            o_cop_waddr <= dest.rd;
            o_cop_wdata <= p_data;   // Held through CPU back-pressure
        end
    end

    a_one_unit_done: assert property (@(posedge g_clk) palu.done |-> !perm.done)
        else $error("Both units finished in the same cycle");

endmodule

// ==== src/cop_top.sv ====
// ========================================
// Crypto coprocessor top level
// ========================================
`timescale 1ns/1ps

module cop_top (
    input  logic               g_clk,
    input  logic               g_resetn,
    input  logic               i_cpu_insn_req,   // Instruction request
    output logic               o_cop_insn_ack,   // Request acknowledge
    input  cop_pkg::word_t     i_cpu_insn_enc,
    input  cop_pkg::word_t     i_cpu_rs1,
    output logic               o_cop_wen,        // GPR writeback enable
    output cop_pkg::gpr_addr_t o_cop_waddr,
    output cop_pkg::word_t     o_cop_wdata,
    output cop_pkg::result_t   o_cop_result,
    output logic               o_cop_insn_rsp,   // Instruction finished
    input  logic               i_cpu_insn_ack    // Response acknowledge
);

    logic                  accept;
    logic                  illegal;
    logic                  reject;
    logic                  finish;
    cop_pkg::opcode_t      id_op;
    cop_pkg::pack_width_t  id_pw;
    cop_pkg::shamt_t       id_imm;
    cop_pkg::cpr_addr_t    id_crs1;
    cop_pkg::cpr_addr_t    id_crs2;
    cop_pkg::word_t        id_gpr_rs1;
    cop_pkg::word_t        crs1_rdata;
    cop_pkg::word_t        crs2_rdata;
    logic                  cpr_wen;
    cop_pkg::cpr_addr_t    cpr_waddr;
    cop_pkg::word_t        cpr_wdata;

    cop_unit_if palu_bus ();
    cop_unit_if perm_bus ();
    cop_dest_if dest_bus ();

    cop_decoder u_decoder (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_accept(accept),
        .i_insn_enc(i_cpu_insn_enc), .i_gpr_rs1(i_cpu_rs1),
        .o_op(id_op), .o_pw(id_pw), .o_imm(id_imm), .o_crs1(id_crs1), .o_crs2(id_crs2),
        .o_gpr_rs1(id_gpr_rs1), .o_illegal(illegal), .dest(dest_bus.source)
    );

    cop_regfile u_regfile (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .i_raddr_a(id_crs1), .o_rdata_a(crs1_rdata),
        .i_raddr_b(id_crs2), .o_rdata_b(crs2_rdata),
        .i_wen(cpr_wen), .i_waddr(cpr_waddr), .i_wdata(cpr_wdata)
    );

    cop_issue u_issue (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .i_cpu_insn_req(i_cpu_insn_req), .o_cop_insn_ack(o_cop_insn_ack),
        .o_cop_insn_rsp(o_cop_insn_rsp), .i_cpu_insn_ack(i_cpu_insn_ack),
        .o_accept(accept), .i_op(id_op), .i_pw(id_pw), .i_imm(id_imm),
        .i_illegal(illegal), .i_gpr_rs1(id_gpr_rs1),
        .i_rdata_a(crs1_rdata), .i_rdata_b(crs2_rdata),
        .o_reject(reject), .i_finish(finish),
        .palu(palu_bus.issuer), .perm(perm_bus.issuer)
    );

    cop_packed_alu u_packed_alu (.g_clk(g_clk), .g_resetn(g_resetn), .bus(palu_bus.unit));

    cop_permute_unit u_permute (.g_clk(g_clk), .g_resetn(g_resetn), .bus(perm_bus.unit));

    cop_writeback u_writeback (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .palu(palu_bus.sink), .perm(perm_bus.sink), .dest(dest_bus.sink),
        .i_reject(reject), .o_finish(finish),
        .o_cpr_wen(cpr_wen), .o_cpr_waddr(cpr_waddr), .o_cpr_wdata(cpr_wdata),
        .o_cop_wen(o_cop_wen), .o_cop_waddr(o_cop_waddr),
        .o_cop_wdata(o_cop_wdata), .o_cop_result(o_cop_result)
    );

endmodule

// ==== tests/tb_cop_model.svh ====
// ========================================
// Coprocessor reference model and encoder
// ========================================
`ifndef TB_COP_MODEL_SVH
`define TB_COP_MODEL_SVH

logic [31:0] shadow_cpr [16];   // Expected CPR contents

function automatic logic [31:0] make_enc(input logic [3:0] op, input logic [3:0] crd,
                                         input logic [3:0] crs1, input logic [3:0] crs2,
                                         input logic [1:0] pw, input logic [4:0] imm,
                                         input logic [4:0] rd);
    return {op, crd, crs1, crs2, pw, 1'b0, imm, 3'b000, rd};  // Unused bits zero
endfunction

// Add or subtract per lane, carry out of the lane top is dropped
function automatic logic [31:0] lane_arith(input logic [31:0] a, input logic [31:0] b,
                                           input logic [1:0] pw, input logic sub);
    int          w;
    logic [31:0] m;
    logic [31:0] la;
    logic [31:0] lb;
    logic [31:0] r;
    r = '0;
    w = 32 >> pw;
    m = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);  // Lane mask
    for (int s = 0; s < 32; s += w) begin
        la = (a >> s) & m;
        lb = (b >> s) & m;
        r  = r | (((sub ? la - lb : la + lb) & m) << s);
    end
    return r;
endfunction

function automatic logic [31:0] lane_ror(input logic [31:0] a, input logic [1:0] pw,
                                         input logic [4:0] imm);
    int          w;
    int          r;
    logic [31:0] res;
    w = 32 >> pw;
    r = imm % w;                // Amount wraps at lane width
    for (int i = 0; i < 32; i++) begin
        res[i] = a[(i / w) * w + ((i % w) + r) % w];
    end
    return res;
endfunction

// Stage s exchanges each bit with the one whose index differs in bit s
function automatic logic [31:0] grev_ref(input logic [31:0] a, input logic [4:0] mask);
    logic [31:0] x;
    logic [31:0] t;
    x = a;
    for (int s = 0; s < 5; s++) begin
        if (mask[s]) begin
            for (int i = 0; i < 32; i++) begin
                t[i] = x[i ^ (1 << s)];
            end
            x = t;
        end
    end
    return x;
endfunction

function automatic logic [31:0] pbrev_ref(input logic [31:0] a, input logic [1:0] pw);
    int          w;
    logic [31:0] res;
    w = 32 >> pw;
    for (int i = 0; i < 32; i++) begin
        res[i] = a[(i / w) * w + (w - 1 - i % w)];  // Mirror inside lane
    end
    return res;
endfunction

// Expected GPR response for one instruction, CPR effect goes to shadow_cpr
function automatic void model_exec(input logic [31:0] enc, input logic [31:0] rs1,
                                   output logic wen, output logic [31:0] wdata,
                                   output logic [2:0] result);
    logic [3:0]  op;
    logic [3:0]  crd;
    logic [1:0]  pw;
    logic [4:0]  imm;
    logic [31:0] a;
    logic [31:0] b;
    op     = enc[31:28];
    crd    = enc[27:24];
    a      = shadow_cpr[enc[23:20]];
    b      = shadow_cpr[enc[19:16]];
    pw     = enc[15:14];
    imm    = enc[12:8];
    wen    = 1'b0;
    wdata  = '0;
    result = cop_pkg::RESULT_SUCCESS;
    case (op)
        cop_pkg::OP_PADD:   shadow_cpr[crd] = lane_arith(a, b, pw, 1'b0);
        cop_pkg::OP_PSUB:   shadow_cpr[crd] = lane_arith(a, b, pw, 1'b1);
        cop_pkg::OP_PXOR:   shadow_cpr[crd] = a ^ b;
        cop_pkg::OP_PROR:   shadow_cpr[crd] = lane_ror(a, pw, imm);
        cop_pkg::OP_MV_G2X: shadow_cpr[crd] = rs1;
        cop_pkg::OP_MV_X2G: begin
            wen   = 1'b1;
            wdata = a;
        end
        cop_pkg::OP_GREV:   shadow_cpr[crd] = grev_ref(a, imm);
        cop_pkg::OP_PBREV:  shadow_cpr[crd] = pbrev_ref(a, pw);
        default:            result = cop_pkg::RESULT_BAD_INS;   // Nothing written
    endcase
endfunction

`endif

// ==== tests/tb_cop_top.sv ====
// ========================================
// Testbench for the crypto coprocessor
// ========================================
`timescale 1ns/1ps

module tb_cop_top;

    localparam int WAIT_LIMIT = 20;     // Cycles per handshake wait

    logic        g_clk;
    logic        g_resetn;
    logic        cpu_req;
    logic [31:0] cpu_enc;
    logic [31:0] cpu_rs1;
    logic        cpu_ack;
    logic        o_cop_insn_ack;
    logic        o_cop_wen;
    logic [4:0]  o_cop_waddr;
    logic [31:0] o_cop_wdata;
    logic [2:0]  o_cop_result;
    logic        o_cop_insn_rsp;

    logic        exp_valid;     // Response of current insn expected
    logic        exp_wen;
    logic [4:0]  exp_waddr;
    logic [31:0] exp_wdata;
    logic [2:0]  exp_result;

    logic [31:0] test_enc;      // Encoding of the insn under test

    integer      seed;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          start_errs;

    `include "tb_cop_model.svh"

    cop_top cop_top_inst (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .i_cpu_insn_req(cpu_req), .o_cop_insn_ack(o_cop_insn_ack),
        .i_cpu_insn_enc(cpu_enc), .i_cpu_rs1(cpu_rs1),
        .o_cop_wen(o_cop_wen), .o_cop_waddr(o_cop_waddr),
        .o_cop_wdata(o_cop_wdata), .o_cop_result(o_cop_result),
        .o_cop_insn_rsp(o_cop_insn_rsp), .i_cpu_insn_ack(cpu_ack)
    );

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;     // 40 ns period
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAILED with %0d errors", name, errors - errs_before);
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Runs every response cycle so held outputs stay checked under back-pressure
    always @(posedge g_clk) begin
        if (exp_valid && o_cop_insn_rsp) begin
            check_val("o_cop_result", o_cop_result, exp_result);
            check_val("o_cop_wen", o_cop_wen, exp_wen);
            check_val("o_cop_insn_ack", o_cop_insn_ack, 1'b0);  // No accept meanwhile
            if (exp_wen) begin
                check_val("o_cop_waddr", o_cop_waddr, exp_waddr);
                check_val("o_cop_wdata", o_cop_wdata, exp_wdata);
            end
        end
    end

    // One full CPU transaction with the response taken after up to max_delay cycles
    task automatic run_insn(input logic [31:0] enc, input logic [31:0] rs1,
                            input int max_delay);
        int          n;
        int          delay;
        logic        e_wen;
        logic [31:0] e_data;
        logic [2:0]  e_res;
        model_exec(enc, rs1, e_wen, e_data, e_res);
        exp_wen    <= e_wen;
        exp_waddr  <= enc[4:0];
        exp_wdata  <= e_data;
        exp_result <= e_res;
        exp_valid  <= 1'b1;
        cpu_req    <= 1'b1;
        cpu_enc    <= enc;
        cpu_rs1    <= rs1;
        n = 0;
        do begin
            @(posedge g_clk);
            n++;
        end while (!o_cop_insn_ack && n < WAIT_LIMIT);
        if (!o_cop_insn_ack) stop_on_timeout("instruction acknowledge");
        cpu_req <= 1'b0;                // Accepted at this edge
        n = 0;
        do begin
            @(posedge g_clk);
            n++;
        end while (!o_cop_insn_rsp && n < WAIT_LIMIT);
        if (!o_cop_insn_rsp) stop_on_timeout("instruction response");
        delay = (max_delay > 0) ? rand_below(max_delay + 1) : 0;
        for (int d = 0; d < delay; d++) begin
            @(posedge g_clk);           // CPU holds off the response
            check_val("o_cop_insn_rsp", o_cop_insn_rsp, 1'b1);
        end
        cpu_ack <= 1'b1;
        @(posedge g_clk);               // Response retired here
        check_val("o_cop_insn_rsp", o_cop_insn_rsp, 1'b1);  // Still up when ack seen
        cpu_ack   <= 1'b0;
        exp_valid <= 1'b0;
    endtask

    task automatic read_back(input logic [3:0] crs, input int max_delay);
        run_insn(make_enc(cop_pkg::OP_MV_X2G, 4'd0, crs, 4'd0, 2'd0, 5'd0,
                          5'(rand_below(32))), rand_word(), max_delay);
    endtask

    initial begin
        seed         = 32'h64b4;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        exp_valid    = 1'b0;
        exp_wen      = 1'b0;
        exp_waddr    = '0;
        exp_wdata    = '0;
        exp_result   = '0;
        test_enc     = '0;
        g_resetn     = 1'b0;
        cpu_req      = 1'b0;
        cpu_enc      = '0;
        cpu_rs1      = '0;
        cpu_ack      = 1'b0;
        for (int i = 0; i < 16; i++) begin
            shadow_cpr[i] = '0;         // Matches CPR clear in reset
        end
        repeat (2) @(posedge g_clk);
        g_resetn <= 1'b1;

        start_errs = errors;
        @(posedge g_clk);               // Outputs still at reset values
        check_val("o_cop_insn_rsp", o_cop_insn_rsp, 1'b0);
        check_val("o_cop_wen", o_cop_wen, 1'b0);
        check_val("o_cop_result", o_cop_result, cop_pkg::RESULT_SUCCESS);
        check_val("o_cop_insn_ack", o_cop_insn_ack, 1'b0);
        @(posedge g_clk);               // Raised by the first edge out of reset
        check_val("o_cop_insn_ack", o_cop_insn_ack, 1'b1);
        for (int r = 0; r < 16; r++) begin
            read_back(4'(r), 0);        // All zero after reset
        end
        end_test("reset", start_errs);

        start_errs = errors;
        for (int r = 0; r < 16; r++) begin
            run_insn(make_enc(cop_pkg::OP_MV_G2X, 4'(r), 4'd0, 4'd0, 2'd0, 5'd0,
                              5'(rand_below(32))), rand_word(), 0);
        end
        for (int r = 0; r < 16; r++) begin
            read_back(4'(r), 0);
        end
        end_test("moves", start_errs);

        start_errs = errors;
        for (int k = 0; k < 32; k++) begin
            // k[1:0] picks the op and k[3:2] the pack width
            test_enc = make_enc(4'(k % 4), 4'(rand_below(16)), 4'(rand_below(16)),
                                4'(rand_below(16)), 2'((k / 4) % 4), 5'(rand_below(32)),
                                5'(rand_below(32)));
            run_insn(test_enc, rand_word(), 0);
            read_back(test_enc[27:24], 0);
        end
        end_test("packed arithmetic", start_errs);

        start_errs = errors;
        for (int k = 0; k < 12; k++) begin
            test_enc = make_enc((k < 8) ? cop_pkg::OP_GREV : cop_pkg::OP_PBREV,
                                4'(rand_below(16)), 4'(rand_below(16)), 4'd0, 2'(k % 4),
                                5'(rand_below(32)), 5'd0);
            run_insn(test_enc, rand_word(), 0);
            read_back(test_enc[27:24], 0);
        end
        end_test("permutation", start_errs);

        start_errs = errors;
        for (int c = 8; c < 16; c++) begin
            run_insn(make_enc(4'(c), 4'(rand_below(16)), 4'(rand_below(16)),
                              4'(rand_below(16)), 2'(rand_below(4)), 5'(rand_below(32)),
                              5'(rand_below(32))), rand_word(), 0);
        end
        for (int r = 0; r < 16; r++) begin
            read_back(4'(r), 0);        // CPRs untouched by illegal codes
        end
        end_test("illegal opcodes", start_errs);

        start_errs = errors;
        for (int k = 0; k < 12; k++) begin
            run_insn(make_enc(4'(rand_below(8)), 4'(rand_below(16)), 4'(rand_below(16)),
                              4'(rand_below(16)), 2'(rand_below(4)), 5'(rand_below(32)),
                              5'(rand_below(32))), rand_word(), 6);
            read_back(4'(rand_below(16)), 6);
        end
        end_test("back-pressure", start_errs);

        $display("Tests run %0d, failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+tests
src/cop_pkg.sv
src/cop_ifs.sv
src/cop_decoder.sv
src/cop_regfile.sv
src/cop_issue.sv
src/cop_packed_alu.sv
src/cop_permute_unit.sv
src/cop_writeback.sv
src/cop_top.sv
tests/tb_cop_top.sv
